// ==== design/aes_settings.svh ====
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

//////////////////////////////
// Data widths
//////////////////////////////

// Full state and cipher key
`define AES_BLOCK_W 128

// One column of the state
`define AES_WORD_W 32

`define AES_BYTE_W 8

//////////////////////////////
// Pipeline shape
//////////////////////////////

`define AES_NUM_ROUNDS 10

// Stage 0 plus two cycles per round
`define AES_LATENCY (1 + 2 * `AES_NUM_ROUNDS)

`endif

// ==== design/aes_pkg.sv ====
`default_nettype none

`include "aes_settings.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_W-1:0] aes_block_t;
    typedef logic [`AES_WORD_W-1:0]  aes_word_t;
    typedef logic [`AES_BYTE_W-1:0]  aes_byte_t;

    //////////////////////////////
    // GF(2^8) arithmetic
    //////////////////////////////

    // Multiply by x, reduced by the AES polynomial
    function automatic aes_byte_t xtime(input aes_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t p;
        acc = '0;
        p   = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ p;
            end
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254, which is the inverse; zero maps to zero
    function automatic aes_byte_t gf_inv(input aes_byte_t a);
        aes_byte_t r;
        aes_byte_t p;
        r = 8'h01;
        p = a;
        for (int i = 0; i < 7; i++) begin
            p = gf_mul(p, p);
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    //////////////////////////////
    // Cipher helpers
    //////////////////////////////

    // Inverse followed by the affine map
    function automatic aes_byte_t sbox(input aes_byte_t a);
        aes_byte_t v;
        v = gf_inv(a);
        return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]}
                 ^ {v[3:0], v[7:4]} ^ 8'h63;
    endfunction

    // Round constant for rounds 1 to 10
    function automatic aes_byte_t aes_rcon(input int round);
        aes_byte_t r;
        r = 8'h01;
        for (int i = 1; i < `AES_NUM_ROUNDS; i++) begin
            if (i < round) begin
                r = xtime(r);
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== design/aes_key_expand.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_key_expand import aes_pkg::*; (
    input  logic       clk,
    input  aes_byte_t  rcon,
    input  aes_block_t key_in,
    output aes_block_t round_key,
    output aes_block_t next_key
);

    localparam int NR = `AES_WORD_W / `AES_BYTE_W;

    aes_word_t k0, k1, k2, k3;
    aes_word_t v0, v1, v2, v3;
    aes_word_t v0_q, v1_q, v2_q, v3_q;
    aes_word_t rot_w;
    aes_word_t sub_q;

    assign {k0, k1, k2, k3} = key_in;

    // Running XOR chain, rcon folded into word 0
    assign v0 = k0 ^ {rcon, {(`AES_WORD_W - `AES_BYTE_W){1'b0}}};
    assign v1 = v0 ^ k1;
    assign v2 = v1 ^ k2;
    assign v3 = v2 ^ k3;

    // RotWord on the last column
    assign rot_w = {k3[`AES_WORD_W-`AES_BYTE_W-1:0], k3[`AES_WORD_W-1 -: `AES_BYTE_W]};

    //////////////////////////////
    // Cycle 1
    //////////////////////////////

    always_ff @(posedge clk) begin
        {v0_q, v1_q, v2_q, v3_q} <= {v0, v1, v2, v3};
        for (int i = 0; i < NR; i++) begin
            sub_q[`AES_BYTE_W*i +: `AES_BYTE_W] <= sbox(rot_w[`AES_BYTE_W*i +: `AES_BYTE_W]);
        end
    end

    //////////////////////////////
    // Cycle 2
    //////////////////////////////

    // SubWord lands on every column of the chain
    assign round_key = {v0_q ^ sub_q, v1_q ^ sub_q, v2_q ^ sub_q, v3_q ^ sub_q};

    always_ff @(posedge clk) begin
        next_key <= round_key;
    end

endmodule

`default_nettype wire

// ==== design/aes_round.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_round import aes_pkg::*; #(
    parameter int FINAL = 0
) (
    input  logic       clk,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    localparam int NB = `AES_BLOCK_W / `AES_BYTE_W;
    // Rows in a column
    localparam int NR = `AES_WORD_W / `AES_BYTE_W;

    aes_byte_t  sb_d [NB];
    aes_byte_t  sb_q [NB];
    aes_block_t round_d;

    // Byte 0 is the top byte of the block, columns are 4 bytes apart
    always_comb begin
        for (int b = 0; b < NB; b++) begin
            sb_d[b] = sbox(state_in[`AES_BLOCK_W-1-`AES_BYTE_W*b -: `AES_BYTE_W]);
        end
    end

    always_ff @(posedge clk) begin
        sb_q <= sb_d;
    end

    if (FINAL == 0) begin : g_full
        aes_byte_t db_q [NB];

        always_ff @(posedge clk) begin
            for (int b = 0; b < NB; b++) begin
                db_q[b] <= xtime(sb_d[b]);
            end
        end

        // ShiftRows routing into MixColumns, 3a as 2a ^ a
        always_comb begin
            aes_byte_t a [NR];
            aes_byte_t d [NR];
            int        src;
            for (int c = 0; c < NR; c++) begin
                for (int r = 0; r < NR; r++) begin
                    src  = NR * ((c + r) % NR) + r;
                    a[r] = sb_q[src];
                    d[r] = db_q[src];
                end
                for (int r = 0; r < NR; r++) begin
                    round_d[`AES_BLOCK_W-1-`AES_BYTE_W*(NR*c+r) -: `AES_BYTE_W] =
                        d[r] ^ d[(r+1)%NR] ^ a[(r+1)%NR] ^ a[(r+2)%NR] ^ a[(r+3)%NR];
                end
            end
        end
    end else begin : g_final
        // ShiftRows only
        always_comb begin
            for (int c = 0; c < NR; c++) begin
                for (int r = 0; r < NR; r++) begin
                    round_d[`AES_BLOCK_W-1-`AES_BYTE_W*(NR*c+r) -: `AES_BYTE_W] =
                        sb_q[NR*((c+r)%NR)+r];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        state_out <= round_d ^ round_key;
    end

endmodule

`default_nettype wire

// ==== design/aes_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_core import aes_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  aes_block_t in_state,
    input  aes_block_t in_key,
    output logic       out_valid,
    output aes_block_t out_state
);

    localparam int NRND = `AES_NUM_ROUNDS;

    aes_block_t state_q;
    aes_block_t key_q;
    // Key into expansion stage i+1
    aes_block_t key_chain   [0:NRND-1];
    aes_block_t round_keys  [1:NRND];
    aes_block_t state_chain [0:NRND];
    logic [`AES_LATENCY-1:0] valid_q;

    //////////////////////////////
    // Stage 0, AddRoundKey
    //////////////////////////////

    always_ff @(posedge clk) begin
        state_q <= in_state ^ in_key;
        key_q   <= in_key;
    end

    assign key_chain[0]   = key_q;
    assign state_chain[0] = state_q;

    //////////////////////////////
    // Key and round chains
    //////////////////////////////

    for (genvar i = 1; i <= NRND; i++) begin : g_stage
        if (i < NRND) begin : g_key
            aes_key_expand u_key (
                .clk       (clk),
                .rcon      (aes_rcon(i)),
                .key_in    (key_chain[i-1]),
                .round_key (round_keys[i]),
                .next_key  (key_chain[i])
            );
        end else begin : g_key_last
            // No stage after the last one
            aes_key_expand u_key (
                .clk       (clk),
                .rcon      (aes_rcon(i)),
                .key_in    (key_chain[i-1]),
                .round_key (round_keys[i]),
                .next_key  ()
            );
        end

        aes_round #(
            .FINAL (i == NRND ? 1 : 0)
        ) u_round (
            .clk       (clk),
            .state_in  (state_chain[i-1]),
            .round_key (round_keys[i]),
            .state_out (state_chain[i])
        );
    end

    assign out_state = state_chain[NRND];

    //////////////////////////////
    // Valid pipeline
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[`AES_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_q[`AES_LATENCY-1];

endmodule

`default_nettype wire

// ==== testbench/aes_core_props.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_core_props import aes_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       in_valid,
    input logic       out_valid,
    input aes_block_t out_state
);

    localparam int unsigned LAT = `AES_LATENCY;

    int unsigned fail_count = 0;
    // Clean cycles since the last reset edge, saturating at LAT
    int unsigned run_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_len <= 0;
        end else if (run_len < LAT) begin
            run_len <= run_len + 1;
        end
    end

    //////////////////////////////
    // Valid pipeline
    //////////////////////////////

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        (run_len < LAT) |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high before a block could have crossed the pipeline");
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        (run_len == LAT) |-> (out_valid == $past(in_valid, LAT)))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid by the pipeline latency");
        end

    a_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out_valid))
        else begin
            fail_count++;
            $error("out_valid is unknown");
        end

    a_data_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_state))
        else begin
            fail_count++;
            $error("out_state is unknown while out_valid is high");
        end

endmodule

bind aes_core aes_core_props u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_state (out_state)
);

`default_nettype wire

// ==== testbench/tb_aes_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module tb_aes_core import aes_pkg::*; ();

    localparam int LAT    = `AES_LATENCY;
    localparam int NVEC   = 3;
    localparam int NRAND  = 16;
    // Slack on top of every test budget
    localparam int MARGIN = 20;

    logic       clk;
    logic       rst;
    logic       in_valid;
    aes_block_t in_state;
    aes_block_t in_key;
    logic       out_valid;
    aes_block_t out_state;

    aes_block_t vec_pt  [NVEC];
    aes_block_t vec_key [NVEC];
    aes_block_t vec_ct  [NVEC];

    aes_block_t  exp_q  [$];
    int unsigned sent_q [$];

    int unsigned cycle;
    int unsigned test_start;
    int unsigned budget;
    int          test_num;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errs_at_start;

    aes_core i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_state  (in_state),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_state (out_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Scoreboard
    //////////////////////////////

    // Inputs go out after edge k, results show after edge k + LAT
    always @(negedge clk) begin
        aes_block_t  exp_ct;
        int unsigned sent_cyc;
        if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected output at %0t with no block in flight", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_ct   = exp_q.pop_front();
                sent_cyc = sent_q.pop_front();
                assert (out_state == exp_ct) else begin
                    $display("[FAIL] %0t out_state: got %h, expected %h",
                             $time, out_state, exp_ct);
                    errors++;
                end
                assert (cycle - sent_cyc == LAT) else begin
                    $display("Block sent in cycle %0d came out after %0d cycles instead of %0d",
                             sent_cyc, cycle - sent_cyc, LAT);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (test_num > 0 && cycle - test_start > budget) begin
            $display("Timeout: test %0d ran past its budget of %0d cycles", test_num, budget);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic int total_errors();
        return errors + i_dut.u_props.fail_count;
    endfunction

    task automatic begin_test(input int num, input int cycles);
        test_num      = num;
        test_start    = cycle;
        budget        = cycles + LAT + MARGIN;
        errs_at_start = total_errors();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() != errs_at_start) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", test_num, name,
                 total_errors() == errs_at_start ? "PASS" : "FAIL");
    endtask

    task automatic send_block(input aes_block_t pt, input aes_block_t key, input aes_block_t ct);
        in_valid = 1'b1;
        in_state = pt;
        in_key   = key;
        exp_q.push_back(ct);
        sent_q.push_back(cycle);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Blocks still in flight are lost, so the scoreboard forgets them
    task automatic pulse_reset(input int n);
        rst = 1'b1;
        idle(n);
        exp_q.delete();
        sent_q.delete();
        rst = 1'b0;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int gaps [NRAND];
        int gap_sum;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_state     = '0;
        in_key       = '0;
        cycle        = 0;
        test_num     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'ha45a_b234));

        // FIPS-197 appendix B, appendix C.1, all-zero key and block
        vec_pt[0]  = 128'h3243f6a8885a308d313198a2e0370734;
        vec_key[0] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        vec_ct[0]  = 128'h3925841d02dc09fbdc118597196a0b32;
        vec_pt[1]  = 128'h00112233445566778899aabbccddeeff;
        vec_key[1] = 128'h000102030405060708090a0b0c0d0e0f;
        vec_ct[1]  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        vec_pt[2]  = '0;
        vec_key[2] = '0;
        vec_ct[2]  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

        pulse_reset(4);

        begin_test(1, 30);
        idle(30);
        end_test("quiet after reset");

        begin_test(2, NVEC * (1 + LAT));
        for (int i = 0; i < NVEC; i++) begin
            send_block(vec_pt[i], vec_key[i], vec_ct[i]);
            wait_drain();
        end
        end_test("single known vectors");

        begin_test(3, NVEC);
        for (int i = 0; i < NVEC; i++) begin
            send_block(vec_pt[i], vec_key[i], vec_ct[i]);
        end
        wait_drain();
        end_test("back to back vectors");

        gap_sum = 0;
        for (int i = 0; i < NRAND; i++) begin
            gaps[i] = $urandom_range(3);
            gap_sum += gaps[i];
        end
        begin_test(4, NRAND + gap_sum);
        for (int i = 0; i < NRAND; i++) begin
            send_block(vec_pt[i % NVEC], vec_key[i % NVEC], vec_ct[i % NVEC]);
            idle(gaps[i]);
        end
        wait_drain();
        end_test("random gaps");

        // Reset while three blocks are deep in the pipeline
        begin_test(5, NVEC + 5 + 2 + LAT + 2 + 1);
        for (int i = 0; i < NVEC; i++) begin
            send_block(vec_pt[i], vec_key[i], vec_ct[i]);
        end
        idle(5);
        pulse_reset(2);
        idle(LAT + 2);
        send_block(vec_pt[0], vec_key[0], vec_ct[0]);
        wait_drain();
        end_test("reset mid-stream");

        test_num = 0;
        $display("Tests run: %0d, failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== aes_core.f ====
+incdir+design
design/aes_pkg.sv
design/aes_key_expand.sv
design/aes_round.sv
design/aes_core.sv
testbench/aes_core_props.sv
testbench/tb_aes_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_aes_core
FILELIST  := aes_core.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
